// File: atop_alu.sv
// ----------------------------------------------------------
// AMO arithmetic: old word register and write-back value
// ----------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module atop_alu (
  input  atop_pkg::mem_rsp_t  mem_rsp_i,
  input  logic                clk_i,
  input  logic                rst_ni,
  input  atop_pkg::atop_e     op_i,
  input  atop_pkg::data_t     operand_i,
  output atop_pkg::data_t     amo_result_o
);

  atop_pkg::data_t old_q, old_word;
  logic [32:0]     adder_a, adder_b, sum;
  logic            is_signed, is_cmp, a_lt_b;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      old_q <= '0;
    end else if (mem_rsp_i.rvalid) begin
      old_q <= mem_rsp_i.rdata;
    end
  end

  assign old_word = mem_rsp_i.rvalid ? mem_rsp_i.rdata : old_q;

  // Shared adder, compares by subtracting with one extra sign bit
  always_comb begin
    is_signed = op_i inside {atop_pkg::AMO_MIN, atop_pkg::AMO_MAX};
    is_cmp    = op_i inside {atop_pkg::AMO_MIN, atop_pkg::AMO_MAX,
                             atop_pkg::AMO_MINU, atop_pkg::AMO_MAXU};
    adder_a   = {is_signed & old_word[31], old_word};
    adder_b   = {is_signed & operand_i[31], operand_i};
    if (is_cmp) begin
      adder_b = ~adder_b;
    end
  end

  assign sum    = adder_a + adder_b + {32'd0, is_cmp};
  assign a_lt_b = sum[32];

  always_comb begin
    unique case (op_i)
      atop_pkg::AMO_SWAP: amo_result_o = operand_i;
      atop_pkg::AMO_ADD:  amo_result_o = sum[31:0];
      atop_pkg::AMO_AND:  amo_result_o = old_word & operand_i;
      atop_pkg::AMO_OR:   amo_result_o = old_word | operand_i;
      atop_pkg::AMO_XOR:  amo_result_o = old_word ^ operand_i;
      atop_pkg::AMO_MIN,
      atop_pkg::AMO_MINU: amo_result_o = a_lt_b ? old_word : operand_i;
      atop_pkg::AMO_MAX,
      atop_pkg::AMO_MAXU: amo_result_o = a_lt_b ? operand_i : old_word;
      default:            amo_result_o = '0;
    endcase
  end

endmodule

`default_nettype wire

// File: atop_decode.sv
// ----------------------------------------------------------
// Request classifier and capture register for the
// accepted bus request
// ----------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module atop_decode (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  atop_pkg::bus_req_t  bus_req_i,
  input  logic                accept_i,
  output atop_pkg::op_kind_e  cur_kind_o,
  output atop_pkg::acc_t      acc_o
);

  atop_pkg::acc_t acc_q;

  // LR and SC are atomics too, so test them before bit 5
  always_comb begin
    if (bus_req_i.atop == atop_pkg::ATOP_LR) begin
      cur_kind_o = atop_pkg::KIND_LR;
    end else if (bus_req_i.atop == atop_pkg::ATOP_SC) begin
      cur_kind_o = atop_pkg::KIND_SC;
    end else if (bus_req_i.atop[5]) begin
      cur_kind_o = atop_pkg::KIND_AMO;
    end else begin
      cur_kind_o = atop_pkg::KIND_PLAIN;
    end
  end

  // An AMO always ends in a memory write
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      acc_q <= '0;
    end else if (accept_i) begin
      acc_q.kind  <= cur_kind_o;
      acc_q.op    <= bus_req_i.atop;
      acc_q.addr  <= bus_req_i.addr;
      acc_q.aid   <= bus_req_i.aid;
      acc_q.wdata <= bus_req_i.wdata;
      acc_q.we    <= bus_req_i.we | (cur_kind_o == atop_pkg::KIND_AMO);
    end
  end

  assign acc_o = acc_q;

endmodule

`default_nettype wire

// File: atop_pkg.sv
// ----------------------------------------------------------
// Shared widths, vector types, atomic opcodes and the
// request and response structs of the bus and memory ports
// ----------------------------------------------------------
`default_nettype none

package atop_pkg;

  localparam int unsigned AddrWidth = 32;
  localparam int unsigned DataWidth = 32;
  localparam int unsigned IdWidth   = 4;

  typedef logic [AddrWidth-1:0]   addr_t;
  typedef logic [DataWidth-1:0]   data_t;
  typedef logic [IdWidth-1:0]     id_t;
  typedef logic [DataWidth/8-1:0] strb_t;

  // Bit 5 marks an atomic, the low bits carry the AMO function
  typedef enum logic [5:0] {
    ATOP_NONE = 6'h00,
    AMO_ADD   = 6'h20,
    AMO_SWAP  = 6'h21,
    ATOP_LR   = 6'h22,
    ATOP_SC   = 6'h23,
    AMO_XOR   = 6'h24,
    AMO_OR    = 6'h28,
    AMO_AND   = 6'h2C,
    AMO_MIN   = 6'h30,
    AMO_MAX   = 6'h34,
    AMO_MINU  = 6'h38,
    AMO_MAXU  = 6'h3C
  } atop_e;

  typedef enum logic [1:0] {
    KIND_PLAIN,
    KIND_LR,
    KIND_SC,
    KIND_AMO
  } op_kind_e;

  // ----------------------------------------------------------
  // Port structs
  // ----------------------------------------------------------
  typedef struct packed {
    logic  req;
    logic  we;
    addr_t addr;
    data_t wdata;
    strb_t be;
    id_t   aid;
    atop_e atop;
  } bus_req_t;

  typedef struct packed {
    logic  gnt;
    logic  rvalid;
    data_t rdata;
    id_t   rid;
    logic  err;
    logic  exokay;
  } bus_rsp_t;

  typedef struct packed {
    logic  req;
    logic  we;
    addr_t addr;
    data_t wdata;
    strb_t be;
    id_t   aid;
  } mem_req_t;

  typedef struct packed {
    logic  gnt;
    logic  rvalid;
    data_t rdata;
    logic  err;
  } mem_rsp_t;

  // Request as held after acceptance
  typedef struct packed {
    op_kind_e kind;
    atop_e    op;
    addr_t    addr;
    id_t      aid;
    data_t    wdata;
    logic     we;
  } acc_t;

endpackage

`default_nettype wire

// File: atop_reservation.sv
// ----------------------------------------------------------
// LR reservation record and SC success check
// ----------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module atop_reservation #(
  parameter bit lr_sc_en = 1'b1
) (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  atop_pkg::bus_req_t  bus_req_i,
  input  logic                accept_i,
  input  atop_pkg::op_kind_e  cur_kind_i,
  output logic                sc_ok_o,
  output logic                sc_res_q_o,
  output logic                sc_q_o
);

  typedef struct packed {
    logic            valid;
    atop_pkg::addr_t addr;
    atop_pkg::id_t   core;
  } resv_t;

  resv_t resv_q, resv_d;
  logic  sc_ok;
  logic  sc_q, sc_res_q;
  logic  same_core, same_addr;

  assign same_core = (resv_q.core == bus_req_i.aid);
  assign same_addr = (resv_q.addr == bus_req_i.addr);

  // Success does not wait for the grant, the write enable needs it early
  assign sc_ok = (cur_kind_i == atop_pkg::KIND_SC) && resv_q.valid && same_core && same_addr;

  always_comb begin
    resv_d = resv_q;
    if (accept_i) begin
      // Only the owner may replace a live reservation
      if (cur_kind_i == atop_pkg::KIND_LR && (!resv_q.valid || same_core)) begin
        resv_d.valid = 1'b1;
        resv_d.addr  = bus_req_i.addr;
        resv_d.core  = bus_req_i.aid;
      end
      // Store from another core to the reserved word
      if (!same_core && same_addr &&
          (cur_kind_i == atop_pkg::KIND_AMO || bus_req_i.we)) begin
        resv_d.valid = 1'b0;
      end
      // Any SC of the owner ends the reservation
      if (cur_kind_i == atop_pkg::KIND_SC && resv_q.valid && same_core) begin
        resv_d.valid = 1'b0;
      end
    end
  end

  // SC flags stay until the next accept, so they are valid at the SC's response
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      resv_q   <= '0;
      sc_q     <= 1'b0;
      sc_res_q <= 1'b0;
    end else begin
      resv_q <= resv_d;
      if (accept_i) begin
        sc_q     <= (cur_kind_i == atop_pkg::KIND_SC);
        sc_res_q <= sc_ok;
      end
    end
  end

  assign sc_ok_o    = lr_sc_en & sc_ok;
  assign sc_res_q_o = lr_sc_en & sc_res_q;
  assign sc_q_o     = lr_sc_en & sc_q;

endmodule

`default_nettype wire

// File: atop_resolver.sv
// ----------------------------------------------------------
// Atomic resolver top level: decode, reservation,
// sequencer, ALU and response path
// ----------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module atop_resolver #(
  parameter bit lr_sc_en = 1'b1
) (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  atop_pkg::bus_req_t  bus_req_i,
  output atop_pkg::bus_rsp_t  bus_rsp_o,
  output atop_pkg::mem_req_t  mem_req_o,
  input  atop_pkg::mem_rsp_t  mem_rsp_i
);

  atop_pkg::op_kind_e cur_kind;
  atop_pkg::acc_t     acc;
  atop_pkg::atop_e    amo_op;
  atop_pkg::data_t    amo_result;
  atop_pkg::bus_rsp_t rsp;
  logic               accept, gnt, amo_wb, buf_empty;
  logic               sc_ok, sc_res_q, sc_q;

  atop_decode i_decode (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .bus_req_i  (bus_req_i),
    .accept_i   (accept),
    .cur_kind_o (cur_kind),
    .acc_o      (acc)
  );

  atop_reservation #(
    .lr_sc_en (lr_sc_en)
  ) i_reservation (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .bus_req_i  (bus_req_i),
    .accept_i   (accept),
    .cur_kind_i (cur_kind),
    .sc_ok_o    (sc_ok),
    .sc_res_q_o (sc_res_q),
    .sc_q_o     (sc_q)
  );

  atop_sequencer i_sequencer (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .bus_req_i    (bus_req_i),
    .cur_kind_i   (cur_kind),
    .acc_i        (acc),
    .sc_ok_i      (sc_ok),
    .buf_empty_i  (buf_empty),
    .mem_rsp_i    (mem_rsp_i),
    .amo_result_i (amo_result),
    .mem_req_o    (mem_req_o),
    .gnt_o        (gnt),
    .accept_o     (accept),
    .amo_wb_o     (amo_wb),
    .amo_op_o     (amo_op)
  );

  // Operand is the captured write data of the AMO
  atop_alu i_alu (
    .mem_rsp_i    (mem_rsp_i),
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .op_i         (amo_op),
    .operand_i    (acc.wdata),
    .amo_result_o (amo_result)
  );

  atop_response i_response (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .accept_i    (accept),
    .aid_i       (bus_req_i.aid),
    .mem_rsp_i   (mem_rsp_i),
    .amo_wb_i    (amo_wb),
    .sc_q_i      (sc_q),
    .sc_res_i    (sc_res_q),
    .buf_empty_o (buf_empty),
    .bus_rsp_o   (rsp)
  );

  always_comb begin
    bus_rsp_o     = rsp;
    bus_rsp_o.gnt = gnt;
  end

endmodule

`default_nettype wire

// File: atop_response.sv
// ----------------------------------------------------------
// In-order response path: ID queue, fall-through data
// queue and SC result substitution
// ----------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module atop_response (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  logic                accept_i,
  input  atop_pkg::id_t       aid_i,
  input  atop_pkg::mem_rsp_t  mem_rsp_i,
  input  logic                amo_wb_i,
  input  logic                sc_q_i,
  input  logic                sc_res_i,
  output logic                buf_empty_o,
  output atop_pkg::bus_rsp_t  bus_rsp_o
);

  typedef struct packed {
    atop_pkg::data_t data;
    logic            err;
    logic            exokay;
  } rsp_entry_t;

  logic          wb_q;
  logic          pop;
  atop_pkg::id_t id_mem_q [2];
  logic          id_wr_q, id_rd_q;
  logic [1:0]    id_cnt_q;
  logic          id_valid;
  rsp_entry_t    d_mem_q [2];
  logic          d_wr_q, d_rd_q;
  logic [1:0]    d_cnt_q;
  logic          d_push, d_empty, d_store, d_take, d_valid;
  rsp_entry_t    d_in, d_out;

  // Marks the memory response that belongs to a write-back
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wb_q <= 1'b0;
    end else if (mem_rsp_i.gnt) begin
      wb_q <= amo_wb_i;
    end
  end

  // SC answers 0 on success and 1 on failure
  assign d_in.data   = sc_q_i ? {{(atop_pkg::DataWidth-1){1'b0}}, ~sc_res_i} : mem_rsp_i.rdata;
  assign d_in.err    = mem_rsp_i.err;
  assign d_in.exokay = sc_q_i & sc_res_i;

  assign d_push  = mem_rsp_i.rvalid & ~wb_q;
  assign d_empty = (d_cnt_q == 2'd0);
  assign d_valid = ~d_empty | d_push;
  assign d_out   = d_empty ? d_in : d_mem_q[d_rd_q];

  assign id_valid = (id_cnt_q != 2'd0);
  assign pop      = id_valid & d_valid;
  assign d_take   = pop & ~d_empty;
  assign d_store  = d_push & ~(d_empty & pop);

  // Room for a new request on both queues
  assign buf_empty_o = d_empty & (id_cnt_q != 2'd2);

  // ----------------------------------------------------------
  // Queue pointers
  // ----------------------------------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      id_wr_q  <= 1'b0;
      id_rd_q  <= 1'b0;
      id_cnt_q <= 2'd0;
      d_wr_q   <= 1'b0;
      d_rd_q   <= 1'b0;
      d_cnt_q  <= 2'd0;
    end else begin
      if (accept_i) id_wr_q <= ~id_wr_q;
      if (pop) id_rd_q <= ~id_rd_q;
      id_cnt_q <= id_cnt_q + {1'b0, accept_i} - {1'b0, pop};
      if (d_store) d_wr_q <= ~d_wr_q;
      if (d_take) d_rd_q <= ~d_rd_q;
      d_cnt_q <= d_cnt_q + {1'b0, d_store} - {1'b0, d_take};
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept_i) begin
      id_mem_q[id_wr_q] <= aid_i;
    end
    if (d_store) begin
      d_mem_q[d_wr_q] <= d_in;
    end
  end

  // Bus grant is merged in at the top level
  always_comb begin
    bus_rsp_o.gnt    = 1'b0;
    bus_rsp_o.rvalid = pop;
    bus_rsp_o.rdata  = d_out.data;
    bus_rsp_o.rid    = id_mem_q[id_rd_q];
    bus_rsp_o.err    = d_out.err;
    bus_rsp_o.exokay = d_out.exokay;
  end

endmodule

`default_nettype wire

// File: atop_sequencer.sv
// ----------------------------------------------------------
// Memory port owner: passes requests through, grants the
// bus and issues the AMO write-back
// ----------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module atop_sequencer (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  atop_pkg::bus_req_t  bus_req_i,
  input  atop_pkg::op_kind_e  cur_kind_i,
  input  atop_pkg::acc_t      acc_i,
  input  logic                sc_ok_i,
  input  logic                buf_empty_i,
  input  atop_pkg::mem_rsp_t  mem_rsp_i,
  input  atop_pkg::data_t     amo_result_i,
  output atop_pkg::mem_req_t  mem_req_o,
  output logic                gnt_o,
  output logic                accept_o,
  output logic                amo_wb_o,
  output atop_pkg::atop_e     amo_op_o
);

  typedef enum logic {
    IDLE,
    DO_AMO
  } state_e;

  state_e state_q, state_d;
  logic   wb_active;

  // No bus grant while the write-back owns the port
  assign gnt_o    = mem_rsp_i.gnt & buf_empty_i & (state_q == IDLE);
  assign accept_o = bus_req_i.req & gnt_o;

  assign wb_active = (state_q == DO_AMO) && (acc_i.kind == atop_pkg::KIND_AMO);
  assign amo_wb_o  = wb_active;
  assign amo_op_o  = wb_active ? acc_i.op : atop_pkg::ATOP_NONE;

  // ----------------------------------------------------------
  // Port mux and next state
  // ----------------------------------------------------------
  always_comb begin
    mem_req_o.req   = bus_req_i.req & buf_empty_i;
    mem_req_o.we    = bus_req_i.we;
    mem_req_o.addr  = bus_req_i.addr;
    mem_req_o.wdata = bus_req_i.wdata;
    mem_req_o.be    = bus_req_i.be;
    mem_req_o.aid   = bus_req_i.aid;
    state_d         = state_q;

    unique case (state_q)
      IDLE: begin
        // AMO starts with a read of the old word
        if (cur_kind_i == atop_pkg::KIND_AMO) begin
          mem_req_o.we = 1'b0;
        end
        // Failed SC turns into a read
        if (cur_kind_i == atop_pkg::KIND_SC) begin
          mem_req_o.we = sc_ok_i;
        end
        if (accept_o && cur_kind_i == atop_pkg::KIND_AMO) begin
          state_d = DO_AMO;
        end
      end
      DO_AMO: begin
        mem_req_o.req   = wb_active;
        mem_req_o.we    = acc_i.we;
        mem_req_o.addr  = acc_i.addr;
        mem_req_o.wdata = amo_result_i;
        mem_req_o.be    = '1;
        mem_req_o.aid   = acc_i.aid;
        if (mem_rsp_i.gnt) begin
          state_d = IDLE;
        end
      end
      default: begin
        state_d = IDLE;
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= IDLE;
    end else begin
      state_q <= state_d;
    end
  end

endmodule

`default_nettype wire

// File: files.f
atop_pkg.sv
atop_decode.sv
atop_reservation.sv
atop_sequencer.sv
atop_alu.sv
atop_response.sv
atop_resolver.sv
tb_mem_model.sv
tb_atop_resolver.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the atomic resolver testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f files.f --top-module tb_atop_resolver -o sim_tb
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/sim_tb > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
fi

if grep -qx "TB PASSED" sim.log; then
  exit 0
fi
exit 1

// File: tb_atop_resolver.sv
// ----------------------------------------------------------
// Testbench for the atomic resolver: directed and random
// traffic, reference memory and response checks
// ----------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module tb_atop_resolver;

  localparam int unsigned MaxCycles = 4000;

  typedef struct packed {
    atop_pkg::id_t   rid;
    atop_pkg::data_t rdata;
    logic            exokay;
    logic            chk_data;
  } exp_t;

  logic               clk_i, rst_ni;
  atop_pkg::bus_req_t bus_req;
  atop_pkg::bus_rsp_t bus_rsp;
  atop_pkg::mem_req_t mem_req;
  atop_pkg::mem_rsp_t mem_rsp;

  atop_pkg::data_t ref_mem [64];
  exp_t            exp_q [$];
  int unsigned     cycles;
  logic            rv;
  atop_pkg::addr_t r_addr;
  atop_pkg::id_t   r_id;
  logic            amo_pending;
  atop_pkg::addr_t amo_addr;
  atop_pkg::id_t   amo_aid;
  atop_pkg::data_t amo_wdata;

  atop_resolver #(.lr_sc_en(1'b1)) UUT (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .bus_req_i (bus_req),
    .bus_rsp_o (bus_rsp),
    .mem_req_o (mem_req),
    .mem_rsp_i (mem_rsp)
  );

  tb_mem_model #(.Words(64)) i_mem (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .mem_req_i (mem_req),
    .mem_rsp_o (mem_rsp)
  );

  initial begin
    clk_i = 1'b0;
    forever #10 clk_i = ~clk_i;
  end

  task automatic fail_now(input string msg);
    $display("error at %0t ns: %s", $time, msg);
    $display("TB FAILED");
    $fatal(1);
  endtask

  function automatic atop_pkg::data_t amo_apply(atop_pkg::atop_e op, atop_pkg::data_t old,
                                                atop_pkg::data_t opd);
    case (op)
      atop_pkg::AMO_SWAP: return opd;
      atop_pkg::AMO_ADD:  return old + opd;
      atop_pkg::AMO_AND:  return old & opd;
      atop_pkg::AMO_OR:   return old | opd;
      atop_pkg::AMO_XOR:  return old ^ opd;
      atop_pkg::AMO_MIN:  return ($signed(old) < $signed(opd)) ? old : opd;
      atop_pkg::AMO_MAX:  return ($signed(old) > $signed(opd)) ? old : opd;
      atop_pkg::AMO_MINU: return (old < opd) ? old : opd;
      default:            return (old > opd) ? old : opd;
    endcase
  endfunction

  // ----------------------------------------------------------
  // Reference model and response checker
  // ----------------------------------------------------------
  task automatic model_accept();
    exp_t          e;
    logic [5:0]    idx;
    logic          ok, other;
    atop_pkg::atop_e op;
    idx   = bus_req.addr[7:2];
    op    = bus_req.atop;
    other = (r_id != bus_req.aid) && (r_addr == bus_req.addr);
    e     = '{rid: bus_req.aid, rdata: ref_mem[idx], exokay: 1'b0, chk_data: 1'b1};
    if (op == atop_pkg::ATOP_LR) begin
      if (!rv || r_id == bus_req.aid) begin
        rv     = 1'b1;
        r_addr = bus_req.addr;
        r_id   = bus_req.aid;
      end
    end else if (op == atop_pkg::ATOP_SC) begin
      ok = rv && (r_id == bus_req.aid) && (r_addr == bus_req.addr);
      if (ok) ref_mem[idx] = bus_req.wdata;
      e.rdata  = ok ? 32'd0 : 32'd1;
      e.exokay = ok;
      if (rv && (other || r_id == bus_req.aid)) rv = 1'b0;
    end else if (op != atop_pkg::ATOP_NONE) begin
      ref_mem[idx] = amo_apply(op, ref_mem[idx], bus_req.wdata);
      if (other) rv = 1'b0;
      amo_pending = 1'b1;
      amo_addr    = bus_req.addr;
      amo_aid     = bus_req.aid;
      amo_wdata   = ref_mem[idx];
    end else if (bus_req.we) begin
      ref_mem[idx] = bus_req.wdata;
      e.chk_data   = 1'b0;
      if (other) rv = 1'b0;
    end
    exp_q.push_back(e);
  endtask

  always @(posedge clk_i) begin
    exp_t e;
    if (rst_ni) begin
      cycles++;
      if (cycles >= MaxCycles) begin
        $display("timeout: the run did not finish within %0d cycles", MaxCycles);
        $display("TB FAILED");
        $fatal(1);
      end
      if (amo_pending) begin
        assert (!bus_rsp.gnt) else fail_now("bus gnt high during AMO write-back");
        if (mem_req.req && mem_rsp.gnt) begin
          assert (mem_req.we && mem_req.be == '1 && mem_req.addr == amo_addr &&
                  mem_req.aid == amo_aid && mem_req.wdata == amo_wdata)
            else fail_now($sformatf("write-back addr %08h wdata %08h, expected %08h %08h",
                                    mem_req.addr, mem_req.wdata, amo_addr, amo_wdata));
          amo_pending = 1'b0;
        end
      end
      if (bus_rsp.rvalid) begin
        assert (exp_q.size() != 0) else fail_now("response without a pending request");
        e = exp_q.pop_front();
        assert (bus_rsp.rid == e.rid)
          else fail_now($sformatf("rid %0h, expected %0h", bus_rsp.rid, e.rid));
        assert (!e.chk_data || bus_rsp.rdata == e.rdata)
          else fail_now($sformatf("rdata %08h, expected %08h", bus_rsp.rdata, e.rdata));
        assert (bus_rsp.exokay == e.exokay && !bus_rsp.err)
          else fail_now($sformatf("exokay %0b err %0b", bus_rsp.exokay, bus_rsp.err));
      end
      if (bus_req.req && bus_rsp.gnt) model_accept();
    end else begin
      assert (!bus_rsp.rvalid) else fail_now("rvalid high during reset");
    end
  end

  // ----------------------------------------------------------
  // Stimulus
  // ----------------------------------------------------------
  task automatic issue(input logic we, input int idx, input atop_pkg::data_t wdata,
                       input int aid, input atop_pkg::atop_e op);
    @(negedge clk_i);
    bus_req.req   = 1'b1;
    bus_req.we    = we;
    bus_req.addr  = {24'd0, idx[5:0], 2'b00};
    bus_req.wdata = wdata;
    bus_req.be    = '1;
    bus_req.aid   = atop_pkg::id_t'(aid);
    bus_req.atop  = op;
    do @(posedge clk_i); while (!bus_rsp.gnt);
    @(negedge clk_i);
    bus_req.req = 1'b0;
  endtask

  atop_pkg::atop_e amo_ops [9] = '{atop_pkg::AMO_SWAP, atop_pkg::AMO_ADD, atop_pkg::AMO_AND,
                                   atop_pkg::AMO_OR, atop_pkg::AMO_XOR, atop_pkg::AMO_MIN,
                                   atop_pkg::AMO_MAX, atop_pkg::AMO_MINU, atop_pkg::AMO_MAXU};

  initial begin
    int sel;
    void'($urandom(32'h1223_78bd));
    for (int i = 0; i < 64; i++) ref_mem[i] = (i * 32'h9E37_79B1) ^ 32'h5A3C_0F0F;
    bus_req     = '0;
    rst_ni      = 1'b0;
    rv          = 1'b0;
    r_addr      = '0;
    r_id        = '0;
    amo_pending = 1'b0;
    amo_addr    = '0;
    amo_aid     = '0;
    amo_wdata   = '0;
    repeat (4) @(negedge clk_i);
    rst_ni = 1'b1;
    // Plain writes followed by read-back
    for (int i = 0; i < 8; i++) issue(1'b1, i, 32'hC0DE_0000 + i, i, atop_pkg::ATOP_NONE);
    for (int i = 0; i < 8; i++) issue(1'b0, i, '0, 15 - i, atop_pkg::ATOP_NONE);
    // Each AMO on a negative old word followed by a read
    for (int k = 0; k < 9; k++) begin
      issue(1'b1, 8 + k, 32'hFFFF_FFF0 - k, 1, atop_pkg::ATOP_NONE);
      issue(1'b0, 8 + k, 32'h0000_0005 + k, 2, amo_ops[k]);
      issue(1'b0, 8 + k, '0, 3, atop_pkg::ATOP_NONE);
    end
    // Clean and broken LR/SC pairs
    issue(1'b0, 20, '0, 2, atop_pkg::ATOP_LR);
    issue(1'b1, 20, 32'h1234_5678, 2, atop_pkg::ATOP_SC);
    issue(1'b0, 20, '0, 2, atop_pkg::ATOP_NONE);
    issue(1'b1, 20, 32'hDEAD_BEEF, 2, atop_pkg::ATOP_SC);
    issue(1'b0, 20, '0, 2, atop_pkg::ATOP_NONE);
    issue(1'b0, 21, '0, 3, atop_pkg::ATOP_LR);
    issue(1'b1, 21, 32'h0000_0AAA, 5, atop_pkg::ATOP_NONE);
    issue(1'b1, 21, 32'h0000_0BBB, 3, atop_pkg::ATOP_SC);
    issue(1'b0, 22, '0, 4, atop_pkg::ATOP_LR);
    issue(1'b0, 22, 32'h0000_0010, 6, atop_pkg::AMO_ADD);
    issue(1'b1, 22, 32'h0000_0CCC, 4, atop_pkg::ATOP_SC);
    issue(1'b0, 22, '0, 4, atop_pkg::ATOP_NONE);
    // Mixed random traffic under grant stalls
    for (int n = 0; n < 200; n++) begin
      sel = $urandom_range(4, 0);
      case (sel)
        0: issue(1'b1, $urandom_range(15, 0), $urandom, $urandom, atop_pkg::ATOP_NONE);
        1: issue(1'b0, $urandom_range(15, 0), '0, $urandom, atop_pkg::ATOP_NONE);
        2: issue(1'b0, $urandom_range(15, 0), $urandom, $urandom,
                 amo_ops[$urandom_range(8, 0)]);
        3: issue(1'b0, $urandom_range(15, 0), '0, $urandom_range(3, 0), atop_pkg::ATOP_LR);
        default: issue(1'b1, $urandom_range(15, 0), $urandom, $urandom_range(3, 0),
                       atop_pkg::ATOP_SC);
      endcase
    end
    while (exp_q.size() != 0) @(posedge clk_i);
    repeat (5) @(posedge clk_i);
    $display("TB PASSED");
    $finish;
  end

endmodule

`default_nettype wire

// File: tb_mem_model.sv
// ----------------------------------------------------------
// Testbench word memory with random grant stalls and a
// one-cycle read response
// ----------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module tb_mem_model #(
  parameter int unsigned Words = 64
) (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  atop_pkg::mem_req_t  mem_req_i,
  output atop_pkg::mem_rsp_t  mem_rsp_o
);

  atop_pkg::data_t mem [Words];
  atop_pkg::data_t rdata_q;
  logic            gnt_q, rvalid_q, take;
  logic [5:0]      idx;

  assign idx  = mem_req_i.addr[7:2];
  assign take = mem_req_i.req & gnt_q;

  // Fill pattern mixes the whole word index
  initial begin
    for (int i = 0; i < Words; i++) begin
      mem[i] = (i * 32'h9E37_79B1) ^ 32'h5A3C_0F0F;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      gnt_q    <= 1'b1;
      rvalid_q <= 1'b0;
      rdata_q  <= '0;
    end else begin
      // Roughly one stall in four cycles
      gnt_q    <= ($urandom_range(3, 0) != 0);
      rvalid_q <= take;
      if (take) begin
        if (mem_req_i.we) begin
          for (int b = 0; b < 4; b++) begin
            if (mem_req_i.be[b]) mem[idx][8*b +: 8] <= mem_req_i.wdata[8*b +: 8];
          end
        end
        rdata_q <= mem_req_i.we ? '0 : mem[idx];
      end
    end
  end

  always_comb begin
    mem_rsp_o.gnt    = gnt_q;
    mem_rsp_o.rvalid = rvalid_q;
    mem_rsp_o.rdata  = rdata_q;
    mem_rsp_o.err    = 1'b0;
  end

endmodule

`default_nettype wire
